// ==== common/openadc_pkg.sv ====
package openadc_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_byte_t;
   typedef logic [9:0]  adc_word_t;
   typedef logic [31:0] sample_cnt_t;   // max samples and trigger length
   typedef logic [15:0] decimate_t;     // decimation factor minus one
   typedef logic [31:0] offset_t;       // in adc cycles

   localparam reg_addr_t GAIN_ADDR        = 8'd0;
   localparam reg_addr_t SETTINGS_ADDR    = 8'd1;
   localparam reg_addr_t STATUS_ADDR      = 8'd2;
   localparam reg_addr_t ECHO_ADDR        = 8'd4;
   localparam reg_addr_t EXTFREQ_ADDR     = 8'd5;
   localparam reg_addr_t VERSION_ADDR     = 8'd8;
   localparam reg_addr_t DECIMATE_ADDR    = 8'd15;
   localparam reg_addr_t SAMPLES_ADDR     = 8'd16;
   localparam reg_addr_t TRIGGER_DUR_ADDR = 8'd20;
   localparam reg_addr_t OFFSET_ADDR      = 8'd26;
   localparam reg_addr_t RESET_ADDR       = 8'd28;

   localparam int SET_TRIG_MODE   = 0;  // 0 rising edge, 1 level high
   localparam int SET_ARM         = 1;
   localparam int SET_TRIG_NOW    = 2;  // software trigger
   localparam int SET_TRIG_INVERT = 3;

   localparam int ST_ARMED     = 0;
   localparam int ST_TRIGGERED = 1;
   localparam int ST_DONE      = 2;

   localparam logic [4:0] HW_TYPE          = 5'd8;
   localparam logic [2:0] HW_VER           = 3'd0;
   localparam logic [3:0] REGISTER_VERSION = 4'd1;

   typedef enum logic [1:0] {
      TS_IDLE,
      TS_WAIT_TRIG,
      TS_OFFSET,
      TS_RUN
   } trig_state_t;

   typedef enum logic [1:0] {
      CS_IDLE,
      CS_CAPTURE,
      CS_DONE
   } cap_state_t;

endpackage

// ==== hw/reg_openadc/reg_openadc.sv ====
`timescale 1ns/1ps

module reg_openadc #(
   parameter int pBYTECNT_SIZE    = 7,
   parameter int pDEFAULT_SAMPLES = 64
) (
   input  logic                     clk_usb,
   input  logic                     reset_i,
   input  openadc_pkg::reg_addr_t   reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0] reg_bytecnt_i,
   input  openadc_pkg::reg_byte_t   reg_datai_i,
   input  logic                     reg_read_i,
   input  logic                     reg_write_i,
   output openadc_pkg::reg_byte_t   reg_datao_o,
   output logic                     reset_o,
   output openadc_pkg::reg_byte_t   gain_o,
   output logic                     trig_mode_o,
   output logic                     arm_o,
   output logic                     trig_now_o,
   output logic                     trig_invert_o,
   output openadc_pkg::offset_t     offset_o,
   output openadc_pkg::decimate_t   decimate_o,
   output openadc_pkg::sample_cnt_t max_samples_o,
   input  logic                     armed_i,
   input  logic                     triggered_i,
   input  logic                     done_i,
   input  openadc_pkg::sample_cnt_t trigger_length_i,
   input  openadc_pkg::sample_cnt_t ext_freq_i
);
   import openadc_pkg::*;

   reg_byte_t   gain_q;
   reg_byte_t   settings_q;
   reg_byte_t   echo_q;
   decimate_t   decimate_q;
   sample_cnt_t samples_q;
   offset_t     offset_q;
   logic        soft_reset = 1'b0;   // survives its own reset
   logic [1:0]  lane;
   logic        lane_ok;
   logic [2:0]  status_meta;
   logic [2:0]  status_sync;
   reg_byte_t   status_byte;
   logic [31:0] version_word;

   assign lane    = reg_bytecnt_i[1:0];
   assign lane_ok = (reg_bytecnt_i < 4);   // 32-bit registers have four lanes
   assign reset_o = reset_i | soft_reset;

   assign gain_o        = gain_q;
   assign trig_mode_o   = settings_q[SET_TRIG_MODE];
   assign arm_o         = settings_q[SET_ARM];
   assign trig_now_o    = settings_q[SET_TRIG_NOW];
   assign trig_invert_o = settings_q[SET_TRIG_INVERT];
   assign offset_o      = offset_q;
   assign decimate_o    = decimate_q;
   assign max_samples_o = samples_q;

   assign version_word = {16'h0000, HW_TYPE, HW_VER, 4'h0, REGISTER_VERSION};

   // selected byte lane of a 32-bit value, zero past the top lane
   function automatic reg_byte_t pick(input logic [31:0] word);
      return lane_ok ? word[lane*8 +: 8] : 8'h00;
   endfunction

   always_ff @(posedge clk_usb) begin
      if (reset_o) begin
         gain_q     <= '0;
         settings_q <= '0;
         echo_q     <= '0;
         decimate_q <= '0;
         offset_q   <= '0;
         samples_q  <= sample_cnt_t'(pDEFAULT_SAMPLES);
      end else if (reg_write_i) begin
         case (reg_address_i)
            GAIN_ADDR:     gain_q     <= reg_datai_i;
            SETTINGS_ADDR: settings_q <= reg_datai_i;
            ECHO_ADDR:     echo_q     <= reg_datai_i;
            DECIMATE_ADDR: begin
               if (lane_ok && !lane[1]) decimate_q[lane[0]*8 +: 8] <= reg_datai_i;   // two lanes
            end
            SAMPLES_ADDR: begin
               if (lane_ok) samples_q[lane*8 +: 8] <= reg_datai_i;
            end
            OFFSET_ADDR: begin
               if (lane_ok) offset_q[lane*8 +: 8] <= reg_datai_i;
            end
            default: ;
         endcase
      end
   end

   // soft reset holds until the host writes 0 back
   always_ff @(posedge clk_usb) begin
      if (reg_write_i && (reg_address_i == RESET_ADDR)) begin
         soft_reset <= reg_datai_i[0];
      end
   end

   // adc-side status into clk_usb
   always_ff @(posedge clk_usb) begin
      if (reset_o) begin
         status_meta <= '0;
         status_sync <= '0;
      end else begin
         status_meta <= {done_i, triggered_i, armed_i};
         status_sync <= status_meta;
      end
   end

   always_comb begin
      status_byte               = '0;
      status_byte[ST_ARMED]     = status_sync[0];
      status_byte[ST_TRIGGERED] = status_sync[1];
      status_byte[ST_DONE]      = status_sync[2];
   end

   always_ff @(posedge clk_usb) begin
      if (reg_read_i) begin
         case (reg_address_i)
            GAIN_ADDR:        reg_datao_o <= gain_q;
            SETTINGS_ADDR:    reg_datao_o <= settings_q;
            STATUS_ADDR:      reg_datao_o <= status_byte;
            ECHO_ADDR:        reg_datao_o <= echo_q;
            EXTFREQ_ADDR:     reg_datao_o <= pick(ext_freq_i);
            VERSION_ADDR:     reg_datao_o <= pick(version_word);
            DECIMATE_ADDR:    reg_datao_o <= pick({16'h0000, decimate_q});
            SAMPLES_ADDR:     reg_datao_o <= pick(samples_q);
            TRIGGER_DUR_ADDR: reg_datao_o <= pick(trigger_length_i);   // stable once done
            OFFSET_ADDR:      reg_datao_o <= pick(offset_q);
            RESET_ADDR:       reg_datao_o <= {7'b0, soft_reset};
            default:          reg_datao_o <= '0;
         endcase
      end else begin
         reg_datao_o <= '0;
      end
   end

endmodule

// ==== hw/trigger/trigger_unit.sv ====
`timescale 1ns/1ps

module trigger_unit (
   input  logic                     adc_clk_i,
   input  logic                     reset_i,
   input  logic                     arm_i,
   input  logic                     trig_mode_i,
   input  logic                     trig_now_i,
   input  logic                     trig_invert_i,
   input  logic                     trigger_i,
   input  openadc_pkg::offset_t     offset_i,
   input  logic                     capture_done_i,
   output logic                     capture_start_o,
   output logic                     adc_reset_o,
   output logic                     armed_o,
   output logic                     triggered_o,
   output openadc_pkg::sample_cnt_t trigger_length_o
);
   import openadc_pkg::*;

   logic [1:0]  reset_sync;
   logic [1:0]  arm_sync;
   logic        arm_s;
   logic        trig_in;
   logic        trig_prev;
   logic        trig_hit;
   logic        detect;
   logic        len_active;
   trig_state_t state;
   offset_t     offset_cnt;

   always_ff @(posedge adc_clk_i) begin
      reset_sync <= {reset_sync[0], reset_i};
   end
   assign adc_reset_o = reset_sync[1];

   always_ff @(posedge adc_clk_i) begin
      if (adc_reset_o) begin
         arm_sync  <= '0;
         trig_prev <= 1'b0;
      end else begin
         arm_sync  <= {arm_sync[0], arm_i};
         trig_prev <= trig_in;
      end
   end

   assign arm_s    = arm_sync[1];
   assign trig_in  = trigger_i ^ trig_invert_i;
   assign trig_hit = trig_now_i | (trig_mode_i ? trig_in : (trig_in & ~trig_prev));
   assign detect   = arm_s && (state == TS_WAIT_TRIG) && trig_hit;

   // zero offset fires in the detection cycle itself
   assign capture_start_o = (detect && (offset_i == '0)) ||
                            (arm_s && (state == TS_OFFSET) && (offset_cnt == '0));

   assign armed_o     = (state != TS_IDLE);
   assign triggered_o = (state == TS_OFFSET) || (state == TS_RUN);

   always_ff @(posedge adc_clk_i) begin
      if (adc_reset_o) begin
         state      <= TS_IDLE;
         offset_cnt <= '0;
      end else if (!arm_s) begin
         state <= TS_IDLE;   // disarm aborts from any state
      end else begin
         case (state)
            TS_IDLE: state <= TS_WAIT_TRIG;
            TS_WAIT_TRIG: begin
               if (trig_hit) begin
                  offset_cnt <= offset_i - 1'b1;
                  state      <= (offset_i == '0) ? TS_RUN : TS_OFFSET;
               end
            end
            TS_OFFSET: begin
               if (offset_cnt == '0) state <= TS_RUN;
               else offset_cnt <= offset_cnt - 1'b1;
            end
            default: ;   // stay in run until disarmed
         endcase
      end
   end

   // high time of the trigger from detection on, frozen once capture ends
   always_ff @(posedge adc_clk_i) begin
      if (adc_reset_o || (arm_s && (state == TS_IDLE))) begin
         trigger_length_o <= '0;
         len_active       <= 1'b0;
      end else if (detect) begin
         trigger_length_o <= trig_in ? sample_cnt_t'(1) : '0;   // trig_now may fire low
         len_active       <= trig_in;
      end else if (len_active) begin
         if (!trig_in || ((state == TS_RUN) && capture_done_i)) begin
            len_active <= 1'b0;
         end else if (trigger_length_o != '1) begin
            trigger_length_o <= trigger_length_o + 1'b1;   // saturates
         end
      end
   end

endmodule

// ==== hw/capture/capture_ctrl.sv ====
`timescale 1ns/1ps

module capture_ctrl (
   input  logic                     adc_clk_i,
   input  logic                     reset_i,
   input  logic                     capture_start_i,
   input  openadc_pkg::adc_word_t   adc_data_i,
   input  openadc_pkg::decimate_t   decimate_i,
   input  openadc_pkg::sample_cnt_t max_samples_i,
   output openadc_pkg::adc_word_t   sample_o,
   output logic                     sample_valid_o,
   output logic                     capture_done_o
);
   import openadc_pkg::*;

   cap_state_t  state;
   decimate_t   dec_cnt;
   sample_cnt_t sample_cnt;
   logic        take;

   // sample slot when the decimation counter runs out
   assign take           = (state == CS_CAPTURE) && (dec_cnt == '0);
   assign capture_done_o = (state == CS_DONE);

   always_ff @(posedge adc_clk_i) begin
      if (reset_i) begin
         state          <= CS_IDLE;
         dec_cnt        <= '0;
         sample_cnt     <= '0;
         sample_valid_o <= 1'b0;
      end else begin
         sample_valid_o <= take;
         case (state)
            CS_IDLE, CS_DONE: begin
               if (capture_start_i) begin
                  state      <= CS_CAPTURE;
                  dec_cnt    <= '0;   // first word right after start
                  sample_cnt <= '0;
               end
            end
            CS_CAPTURE: begin
               if (dec_cnt == '0) begin
                  dec_cnt    <= decimate_i;
                  sample_cnt <= sample_cnt + 1'b1;
                  if ((sample_cnt + 1'b1) >= max_samples_i) begin
                     state <= CS_DONE;   // last word goes out with this edge
                  end
               end else begin
                  dec_cnt <= dec_cnt - 1'b1;
               end
            end
            default: state <= CS_IDLE;
         endcase
      end
   end

   always_ff @(posedge adc_clk_i) begin
      if (take) begin
         sample_o <= adc_data_i;
      end
   end

endmodule

// ==== hw/freq_counter.sv ====
`timescale 1ns/1ps

module freq_counter #(
   parameter int pGATE_CYCLES = 1000
) (
   input  logic                     clk_usb,
   input  logic                     reset_i,
   input  logic                     ext_clk_i,
   output openadc_pkg::sample_cnt_t freq_o
);
   import openadc_pkg::*;

   localparam int GATE_W = (pGATE_CYCLES > 1) ? $clog2(pGATE_CYCLES) : 1;

   logic [2:0]        ext_sync;   // two sync stages plus edge history
   logic              ext_rise;
   logic [GATE_W-1:0] gate_cnt;
   sample_cnt_t       edge_cnt;

   always_ff @(posedge clk_usb) begin
      if (reset_i) ext_sync <= '0;
      else ext_sync <= {ext_sync[1:0], ext_clk_i};
   end

   assign ext_rise = ext_sync[1] & ~ext_sync[2];

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         gate_cnt <= '0;
         edge_cnt <= '0;
         freq_o   <= '0;
      end else if (gate_cnt == GATE_W'(pGATE_CYCLES - 1)) begin
         gate_cnt <= '0;
         freq_o   <= edge_cnt + sample_cnt_t'(ext_rise);   // close the window
         edge_cnt <= '0;
      end else begin
         gate_cnt <= gate_cnt + 1'b1;
         edge_cnt <= edge_cnt + sample_cnt_t'(ext_rise);
      end
   end

endmodule

// ==== hw/openadc_top.sv ====
`timescale 1ns/1ps

module openadc_top #(
   parameter int pBYTECNT_SIZE    = 7,
   parameter int pGATE_CYCLES     = 1000,
   parameter int pDEFAULT_SAMPLES = 64
) (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic                     adc_clk_i,
   input  openadc_pkg::adc_word_t   adc_data_i,
   input  logic                     trigger_i,
   input  logic                     ext_clk_i,
   input  openadc_pkg::reg_addr_t   reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0] reg_bytecnt_i,
   input  openadc_pkg::reg_byte_t   reg_datai_i,
   input  logic                     reg_read_i,
   input  logic                     reg_write_i,
   output openadc_pkg::reg_byte_t   reg_datao_o,
   output openadc_pkg::reg_byte_t   gain_o,
   output openadc_pkg::adc_word_t   sample_o,
   output logic                     sample_valid_o
);
   import openadc_pkg::*;

   logic        reset_all;   // external or soft reset, clk_usb side
   logic        adc_reset;
   logic        trig_mode;
   logic        arm;
   logic        trig_now;
   logic        trig_invert;
   offset_t     offset;
   decimate_t   decimate;
   sample_cnt_t max_samples;
   logic        armed;
   logic        triggered;
   logic        capture_start;
   logic        capture_done;
   sample_cnt_t trigger_length;
   sample_cnt_t ext_freq;

   reg_openadc #(
      .pBYTECNT_SIZE    (pBYTECNT_SIZE),
      .pDEFAULT_SAMPLES (pDEFAULT_SAMPLES)
   ) reg_openadc_inst (
      .clk_usb          (clk_usb),
      .reset_i          (reset),
      .reg_address_i    (reg_address_i),
      .reg_bytecnt_i    (reg_bytecnt_i),
      .reg_datai_i      (reg_datai_i),
      .reg_read_i       (reg_read_i),
      .reg_write_i      (reg_write_i),
      .reg_datao_o      (reg_datao_o),
      .reset_o          (reset_all),
      .gain_o           (gain_o),
      .trig_mode_o      (trig_mode),
      .arm_o            (arm),
      .trig_now_o       (trig_now),
      .trig_invert_o    (trig_invert),
      .offset_o         (offset),
      .decimate_o       (decimate),
      .max_samples_o    (max_samples),
      .armed_i          (armed),
      .triggered_i      (triggered),
      .done_i           (capture_done),
      .trigger_length_i (trigger_length),
      .ext_freq_i       (ext_freq)
   );

   trigger_unit trigger_unit_inst (
      .adc_clk_i        (adc_clk_i),
      .reset_i          (reset_all),
      .arm_i            (arm),
      .trig_mode_i      (trig_mode),
      .trig_now_i       (trig_now),
      .trig_invert_i    (trig_invert),
      .trigger_i        (trigger_i),
      .offset_i         (offset),
      .capture_done_i   (capture_done),
      .capture_start_o  (capture_start),
      .adc_reset_o      (adc_reset),
      .armed_o          (armed),
      .triggered_o      (triggered),
      .trigger_length_o (trigger_length)
   );

   capture_ctrl capture_ctrl_inst (
      .adc_clk_i       (adc_clk_i),
      .reset_i         (adc_reset),
      .capture_start_i (capture_start),
      .adc_data_i      (adc_data_i),
      .decimate_i      (decimate),
      .max_samples_i   (max_samples),
      .sample_o        (sample_o),
      .sample_valid_o  (sample_valid_o),
      .capture_done_o  (capture_done)
   );

   freq_counter #(
      .pGATE_CYCLES (pGATE_CYCLES)
   ) freq_counter_inst (
      .clk_usb   (clk_usb),
      .reset_i   (reset_all),
      .ext_clk_i (ext_clk_i),
      .freq_o    (ext_freq)
   );

endmodule

// ==== bench/openadc_checker.sv ====
`timescale 1ns/1ps

module openadc_checker (
   input logic                   adc_clk_i,
   input openadc_pkg::adc_word_t sample_i,
   input logic                   sample_valid_i
);
   import openadc_pkg::*;

   int        stream_errors = 0;   // found by the stream monitor
   int        check_errors  = 0;   // found by the check tasks
   int        count         = 0;   // valid words seen since time zero
   int        base          = 0;   // count at the start of the current capture
   int        step          = 1;
   string     name          = "reset";
   adc_word_t prev          = '0;
   adc_word_t first         = '0;

   // ramp input, so each word must follow the last by decimate+1
   always @(posedge adc_clk_i) begin
      if (sample_valid_i) begin
         if (count == base) begin
            first = sample_i;
         end else if (adc_word_t'(sample_i - prev) != adc_word_t'(step)) begin
            stream_errors = stream_errors + 1;
            $display("Mismatch %s: expected step %0d, actual step %0d", name, step,
                     adc_word_t'(sample_i - prev));
         end
         prev  = sample_i;
         count = count + 1;
      end
   end

   task automatic start_capture(input string test_name, input int decimate);
      name = test_name;
      step = decimate + 1;
      base = count;
   endtask

   function automatic int captured();
      return count - base;
   endfunction

   function automatic int total_errors();
      return stream_errors + check_errors;
   endfunction

   task automatic check_value(input string test_name, input int expected, input int actual);
      if (expected != actual) begin
         check_errors = check_errors + 1;
         $display("Mismatch %s: expected %0d, actual %0d", test_name, expected, actual);
      end
   endtask

   task automatic check_range(input string test_name, input int lo, input int hi,
                              input int actual);
      if ((actual < lo) || (actual > hi)) begin
         check_errors = check_errors + 1;
         $display("Mismatch %s: expected %0d to %0d, actual %0d", test_name, lo, hi, actual);
      end
   endtask

   // first word relative to the ramp value when the trigger rose
   task automatic finish_capture(input int exp_count, input bit check_first,
                                 input adc_word_t ramp_ref, input int lo, input int hi);
      check_value({name, "_count"}, exp_count, captured());
      if (check_first) begin
         check_range({name, "_first"}, lo, hi, int'(adc_word_t'(first - ramp_ref)));
      end
   endtask

   task automatic report_failure(input string msg);
      check_errors = check_errors + 1;
      $display("%s: %s", name, msg);
   endtask

endmodule

// ==== bench/tb_openadc.sv ====
`timescale 1ns/1ps

module tb_openadc;
   import openadc_pkg::*;

   localparam int GATE        = 1000;
   localparam int DEF_SAMPLES = 64;
   localparam int ROWS        = 4;
   localparam int MODE_EDGE   = 0;
   localparam int MODE_LEVEL  = 1;
   localparam int MODE_SOFT   = 2;

   logic       clk_usb;
   logic       reset;
   logic       adc_clk;
   logic       ext_clk;
   logic       trigger;
   adc_word_t  adc_data;
   reg_addr_t  reg_address;
   logic [6:0] reg_bytecnt;
   reg_byte_t  reg_datai;
   logic       reg_read;
   logic       reg_write;
   reg_byte_t  reg_datao;
   reg_byte_t  gain;
   adc_word_t  sample;
   logic       sample_valid;
   adc_word_t  trig_ramp;
   longint     watch_ns;

   // name, decimate, samples, offset, mode, pulse width, write/readback pair
   string     row_name [ROWS] = '{"edge_d0", "level_d2", "soft_d1", "edge_d4"};
   int        row_dec  [ROWS] = '{0, 2, 1, 4};
   int        row_samp [ROWS] = '{16, 20, 12, 10};
   int        row_off  [ROWS] = '{0, 5, 3, 10};
   int        row_mode [ROWS] = '{MODE_EDGE, MODE_LEVEL, MODE_SOFT, MODE_EDGE};
   int        row_width[ROWS] = '{4, 6, 0, 8};
   reg_addr_t row_waddr[ROWS] = '{ECHO_ADDR, GAIN_ADDR, ECHO_ADDR, GAIN_ADDR};
   reg_byte_t row_wdata[ROWS] = '{8'h5a, 8'h3c, 8'ha5, 8'hff};

   openadc_top #(
      .pGATE_CYCLES     (GATE),
      .pDEFAULT_SAMPLES (DEF_SAMPLES)
   ) openadc_top_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_clk_i      (adc_clk),
      .adc_data_i     (adc_data),
      .trigger_i      (trigger),
      .ext_clk_i      (ext_clk),
      .reg_address_i  (reg_address),
      .reg_bytecnt_i  (reg_bytecnt),
      .reg_datai_i    (reg_datai),
      .reg_read_i     (reg_read),
      .reg_write_i    (reg_write),
      .reg_datao_o    (reg_datao),
      .gain_o         (gain),
      .sample_o       (sample),
      .sample_valid_o (sample_valid)
   );

   openadc_checker checker_inst (
      .adc_clk_i      (adc_clk),
      .sample_i       (sample),
      .sample_valid_i (sample_valid)
   );

   initial begin
      clk_usb = 1'b0;
      forever #5 clk_usb = ~clk_usb;
   end

   initial begin
      adc_clk = 1'b0;
      forever #8 adc_clk = ~adc_clk;
   end

   initial begin
      ext_clk = 1'b0;
      forever #25 ext_clk = ~ext_clk;
   end

   always @(posedge adc_clk) adc_data <= adc_data + 1'b1;   // free-running ramp

   task automatic write_byte(input reg_addr_t addr, input int lane, input reg_byte_t data);
      @(posedge clk_usb);
      reg_address <= addr;
      reg_bytecnt <= 7'(lane);
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge clk_usb);
      reg_write <= 1'b0;
   endtask

   task automatic read_byte(input reg_addr_t addr, input int lane, output reg_byte_t data);
      @(posedge clk_usb);
      reg_address <= addr;
      reg_bytecnt <= 7'(lane);
      reg_read    <= 1'b1;
      @(posedge clk_usb);
      reg_read <= 1'b0;
      @(negedge clk_usb);
      data = reg_datao;   // one cycle after the strobe
   endtask

   task automatic expect_byte(input string name, input reg_addr_t addr, input int lane,
                              input int expected);
      reg_byte_t data;
      read_byte(addr, lane, data);
      checker_inst.check_value(name, expected, int'(data));
   endtask

   task automatic write_word(input reg_addr_t addr, input int lanes, input int value);
      for (int l = 0; l < lanes; l++) write_byte(addr, l, reg_byte_t'(value >> (8 * l)));
   endtask

   task automatic expect_word(input string name, input reg_addr_t addr, input int lanes,
                              input int value);
      for (int l = 0; l < lanes; l++) expect_byte(name, addr, l, (value >> (8 * l)) & 8'hff);
   endtask

   task automatic wait_done(input string name);
      reg_byte_t st;
      int        polls;
      bit        started;
      polls   = 0;
      started = 1'b0;
      st      = '0;
      // done holds from the previous capture until the new one starts
      while (!(started && st[ST_DONE]) && (polls < 2000)) begin
         read_byte(STATUS_ADDR, 0, st);
         if (!st[ST_DONE]) started = 1'b1;
         polls++;
      end
      if (!(started && st[ST_DONE])) begin
         checker_inst.report_failure("capture never reported done");
      end
   endtask

   task automatic run_row(input int i);
      reg_byte_t lo;
      reg_byte_t hi;
      int        off;
      off = row_off[i];
      write_byte(row_waddr[i], 0, row_wdata[i]);
      expect_byte({row_name[i], "_rw"}, row_waddr[i], 0, row_wdata[i]);
      if (row_waddr[i] == GAIN_ADDR) checker_inst.check_value({row_name[i], "_gain"},
                                                             row_wdata[i], gain);
      write_word(DECIMATE_ADDR, 2, row_dec[i]);
      write_word(SAMPLES_ADDR, 4, row_samp[i]);
      write_word(OFFSET_ADDR, 4, off);
      expect_word({row_name[i], "_samples"}, SAMPLES_ADDR, 4, row_samp[i]);
      expect_word({row_name[i], "_offset"}, OFFSET_ADDR, 4, off);
      checker_inst.start_capture(row_name[i], row_dec[i]);
      write_byte(SETTINGS_ADDR, 0, 8'(1 << SET_ARM) | 8'(row_mode[i] == MODE_LEVEL));
      repeat (6 + ($urandom % 8)) @(posedge adc_clk);
      if (row_mode[i] == MODE_SOFT) begin
         repeat (20) @(posedge adc_clk);
         checker_inst.check_value({row_name[i], "_idle"}, 0, checker_inst.captured());
         write_byte(SETTINGS_ADDR, 0, 8'((1 << SET_ARM) | (1 << SET_TRIG_NOW)));
      end else begin
         @(posedge adc_clk);
         trigger   <= 1'b1;
         trig_ramp = adc_data + 1'b1;   // ramp value that comes with the trigger
         repeat (row_width[i]) @(posedge adc_clk);
         trigger <= 1'b0;
      end
      wait_done(row_name[i]);
      repeat (2) @(posedge adc_clk);
      checker_inst.finish_capture(row_samp[i], row_mode[i] != MODE_SOFT, trig_ramp,
                                  off - 1, off + 3);
      if (row_mode[i] != MODE_SOFT) begin
         read_byte(TRIGGER_DUR_ADDR, 0, lo);
         read_byte(TRIGGER_DUR_ADDR, 1, hi);
         checker_inst.check_range({row_name[i], "_dur"}, row_width[i] - 1, row_width[i] + 1,
                                  int'({hi, lo}));
      end
      write_byte(SETTINGS_ADDR, 0, 8'h00);
      repeat (4) @(posedge adc_clk);
   endtask

   // watchdog sized from the table plus the frequency gate windows
   initial begin
      watch_ns = 0;
      for (int i = 0; i < ROWS; i++) begin
         watch_ns += 16 * (row_off[i] + row_samp[i] * (row_dec[i] + 1) + 500);
      end
      watch_ns += 10 * (3 * GATE + 3000);
      #(watch_ns);
      $display("Watchdog expired after %0d ns before the tests completed", watch_ns);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      reg_byte_t f0;
      reg_byte_t f1;
      void'($urandom(32'hcb2d));
      reset       = 1'b1;
      trigger     = 1'b0;
      adc_data    = '0;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai   = '0;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      trig_ramp   = '0;
      repeat (3) @(posedge clk_usb);
      reset <= 1'b0;
      repeat (10) @(posedge clk_usb);

      expect_word("reset_samples", SAMPLES_ADDR, 4, DEF_SAMPLES);
      expect_byte("reset_gain", GAIN_ADDR, 0, 0);
      expect_byte("reset_settings", SETTINGS_ADDR, 0, 0);
      expect_byte("reset_echo", ECHO_ADDR, 0, 0);
      expect_word("reset_decimate", DECIMATE_ADDR, 2, 0);
      expect_word("reset_offset", OFFSET_ADDR, 4, 0);
      expect_byte("version_lo", VERSION_ADDR, 0, {4'h0, REGISTER_VERSION});
      expect_byte("version_hi", VERSION_ADDR, 1, {HW_TYPE, HW_VER});
      checker_inst.check_value("reset_no_samples", 0, checker_inst.captured());

      // every lane carries its own byte
      write_word(OFFSET_ADDR, 4, 32'h1a2b3c4d);
      write_word(SAMPLES_ADDR, 4, 32'h0506a7b8);
      write_word(DECIMATE_ADDR, 2, 32'h0000c3e1);
      expect_word("lanes_offset", OFFSET_ADDR, 4, 32'h1a2b3c4d);
      expect_word("lanes_samples", SAMPLES_ADDR, 4, 32'h0506a7b8);
      expect_word("lanes_decimate", DECIMATE_ADDR, 2, 32'h0000c3e1);

      for (int i = 0; i < ROWS; i++) run_row(i);

      repeat (2 * GATE + 10) @(posedge clk_usb);
      read_byte(EXTFREQ_ADDR, 0, f0);
      read_byte(EXTFREQ_ADDR, 1, f1);
      checker_inst.check_range("extfreq", GATE * 10 / 50 - 1, GATE * 10 / 50 + 1,
                               int'({f1, f0}));

      write_byte(RESET_ADDR, 0, 8'h01);
      expect_byte("soft_reset_held", RESET_ADDR, 0, 1);
      expect_byte("soft_reset_gain", GAIN_ADDR, 0, 0);
      expect_byte("soft_reset_echo", ECHO_ADDR, 0, 0);
      expect_word("soft_reset_decimate", DECIMATE_ADDR, 2, 0);
      expect_word("soft_reset_samples", SAMPLES_ADDR, 4, DEF_SAMPLES);
      expect_word("soft_reset_offset", OFFSET_ADDR, 4, 0);
      write_byte(RESET_ADDR, 0, 8'h00);
      expect_byte("soft_reset_release", RESET_ADDR, 0, 0);
      write_byte(ECHO_ADDR, 0, 8'h96);
      expect_byte("echo_after_release", ECHO_ADDR, 0, 8'h96);

      $display("Run complete with %0d errors", checker_inst.total_errors());
      if (checker_inst.total_errors() == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
common/openadc_pkg.sv
hw/reg_openadc/reg_openadc.sv
hw/trigger/trigger_unit.sv
hw/capture/capture_ctrl.sv
hw/freq_counter.sv
hw/openadc_top.sv
bench/openadc_checker.sv
bench/tb_openadc.sv

// ==== Makefile ====
# Verilator simulation of the capture front end

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log shows success"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -f filelist.f --top-module tb_openadc -o tb_openadc
	./obj_dir/tb_openadc > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
